//--- alu_macros.svh
// ================================================
// alu macros
// data width, stack step, opcode and condition codes
// ================================================
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define ALU_WIDTH      16
`define ALU_STACK_STEP 2

// arithmetic
`define OPC_ADD  8'h00
`define OPC_SUB  8'h01
`define OPC_ADC  8'h02
`define OPC_SBB  8'h03
`define OPC_CMP  8'h04
`define OPC_NEG  8'h09

// logic
`define OPC_AND  8'h05
`define OPC_OR   8'h06
`define OPC_XOR  8'h07
`define OPC_NOT  8'h08
`define OPC_TEST 8'h0a
`define OPC_MOV  8'h0b

// shifts
`define OPC_SHL  8'h0c
`define OPC_SHR  8'h0d
`define OPC_SAR  8'h0e
`define OPC_ROL  8'h0f

// flags, branches, memory, stack
`define OPC_SET  8'h10
`define OPC_LDCP 8'h11
`define OPC_JMP  8'h12
`define OPC_CALL 8'h13
`define OPC_LD   8'h14
`define OPC_ST   8'h15
`define OPC_PUSH 8'h16
`define OPC_POP  8'h17

// condition codes
`define COND_ALWAYS 4'h0
`define COND_NEVER  4'h1
`define COND_EQ     4'h2
`define COND_NE     4'h3
`define COND_CS     4'h4
`define COND_CC     4'h5
`define COND_OS     4'h6
`define COND_OC     4'h7
`define COND_P      4'h8
`define COND_N      4'h9
`define COND_HI     4'ha
`define COND_LS     4'hb
`define COND_GE     4'hc
`define COND_L      4'hd
`define COND_G      4'he
`define COND_LE     4'hf

`endif

//--- alu_pkg.sv
// ================================================
// alu package
// flag nibble, as a word or as named bits
// ================================================
`include "alu_macros.svh"

package alu_pkg;

    // bit 3..0 is v n c z
    typedef union packed {
        logic [3:0] raw;
        struct packed {
            logic v;
            logic n;
            logic c;
            logic z;
        } bits;
    } flags_u;

endpackage

//--- alu_op_if.sv
// ================================================
// alu operation interface
// issued opcode, operands and input flags
// ================================================
`timescale 1ns/1ps
`include "alu_macros.svh"

interface alu_op_if import alu_pkg::*; ();
    logic                   en;
    logic [7:0]             opcode;
    logic [`ALU_WIDTH-1:0]  rd_data;
    logic [`ALU_WIDTH-1:0]  rs_data;
    logic [`ALU_WIDTH-1:0]  immediate;
    logic                   en_imm;
    logic                   mem_displacement;
    logic [3:0]             condition;
    flags_u                 flags_in;

    modport exec (input en, opcode, rd_data, rs_data, immediate, en_imm,
                  mem_displacement, condition, flags_in);
    modport ctrl (input en, opcode);
endinterface

//--- branch_cond.sv
// ================================================
// branch condition
// evaluates a condition code over v n c z
// ================================================
`timescale 1ns/1ps
`include "alu_macros.svh"

module branch_cond import alu_pkg::*; (
    input  logic [3:0] condition,
    input  flags_u     flags,
    output logic       cond_true
);

    logic ge;

    // signed compare, n matches v
    assign ge = (flags.bits.n == flags.bits.v);

    always_comb begin
        case (condition)
            `COND_ALWAYS: cond_true = 1'b1;
            `COND_NEVER:  cond_true = 1'b0;
            `COND_EQ:     cond_true = flags.bits.z;
            `COND_NE:     cond_true = ~flags.bits.z;
            `COND_CS:     cond_true = flags.bits.c;
            `COND_CC:     cond_true = ~flags.bits.c;
            `COND_OS:     cond_true = flags.bits.v;
            `COND_OC:     cond_true = ~flags.bits.v;
            `COND_P:      cond_true = ~flags.bits.n;
            `COND_N:      cond_true = flags.bits.n;
            `COND_HI:     cond_true = ~flags.bits.c & ~flags.bits.z;
            `COND_LS:     cond_true = flags.bits.c | flags.bits.z;
            `COND_GE:     cond_true = ge;
            `COND_L:      cond_true = ~ge;
            `COND_G:      cond_true = ge & ~flags.bits.z;
            `COND_LE:     cond_true = ~ge | flags.bits.z;
            default:      cond_true = 1'b0;
        endcase
    end

endmodule

//--- alu_exec.sv
// ================================================
// alu execution
// operand select, result register, store data,
// stack pointer and result flags
// ================================================
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_exec import alu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    alu_op_if.exec                op,
    input  logic                  cond_true,
    output logic [`ALU_WIDTH-1:0] out,
    output logic [`ALU_WIDTH-1:0] mem_data,
    output logic [`ALU_WIDTH-1:0] sp_out,
    output flags_u                flags_out
);

    localparam int W  = `ALU_WIDTH;
    localparam int SW = $clog2(W);
    localparam logic [W-1:0] STEP = `ALU_STACK_STEP;

    logic [W-1:0]   data1;
    logic [W-1:0]   data2;
    logic [W-1:0]   ea;
    logic [2*W-1:0] rol_wide;
    logic [W:0]     result_d;
    logic [W:0]     result_q;
    logic           is_sub;
    logic           ov_op;
    logic           sign1;
    logic           sign2;

    assign data1    = op.rd_data;
    assign data2    = op.en_imm ? op.immediate : op.rs_data;
    assign ea       = op.mem_displacement ? (op.rs_data + op.immediate) : data2;
    assign rol_wide = {data1, data1} << data2[SW-1:0];
    assign is_sub   = (op.opcode == `OPC_SUB) || (op.opcode == `OPC_SBB) ||
                      (op.opcode == `OPC_CMP);

    // bit W of the result is the carry
    always_comb begin
        case (op.opcode)
            `OPC_ADD:  result_d = {1'b0, data1} + {1'b0, data2};
            `OPC_SUB,
            `OPC_CMP:  result_d = {1'b0, data1} - {1'b0, data2};
            `OPC_ADC:  result_d = {1'b0, data1} + {1'b0, data2} +
                                  {{W{1'b0}}, op.flags_in.bits.c};
            `OPC_SBB:  result_d = {1'b0, data1} - {1'b0, data2} -
                                  {{W{1'b0}}, op.flags_in.bits.c};
            `OPC_AND,
            `OPC_TEST: result_d = {1'b0, data1 & data2};
            `OPC_OR:   result_d = {1'b0, data1 | data2};
            `OPC_XOR:  result_d = {1'b0, data1 ^ data2};
            `OPC_NOT:  result_d = {1'b0, ~data1};
            `OPC_NEG:  result_d = {1'b0, -data1};
            `OPC_MOV:  result_d = {1'b0, data2};
            `OPC_SHL:  result_d = {1'b0, data1} << data2;
            `OPC_SHR:  result_d = {1'b0, data1} >> data2;
            `OPC_SAR:  result_d = {1'b0, $unsigned($signed(data1) >>> data2[SW-1:0])};
            `OPC_ROL:  result_d = {1'b0, rol_wide[2*W-1:W]};
            `OPC_SET:  result_d = {{W{1'b0}}, cond_true};
            // flags only read out for condition 0
            `OPC_LDCP: result_d = (op.condition == 4'h0) ?
                                  {{(W-3){1'b0}}, op.flags_in.raw} : '0;
            `OPC_JMP,
            `OPC_CALL: result_d = {1'b0, op.en_imm ? op.immediate : data1};
            `OPC_LD,
            `OPC_ST:   result_d = {1'b0, ea};
            `OPC_PUSH: result_d = {1'b0, op.rs_data - STEP};
            `OPC_POP:  result_d = {1'b0, op.rs_data};
            default:   result_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
            mem_data <= '0;
            sp_out   <= '0;
            ov_op    <= 1'b0;
        end else if (op.en) begin
            result_q <= result_d;
            ov_op    <= is_sub || (op.opcode == `OPC_ADD) || (op.opcode == `OPC_ADC);
            if (op.opcode == `OPC_ST)
                mem_data <= data1;
            else if (op.opcode == `OPC_PUSH)
                mem_data <= op.en_imm ? op.immediate : op.rd_data;
            if (op.opcode == `OPC_PUSH)
                sp_out <= op.rs_data - STEP;
            else if (op.opcode == `OPC_POP)
                sp_out <= op.rs_data + STEP;
        end
    end

    // operand signs for overflow, second one flipped on subtract
    always_ff @(posedge clk) begin
        if (op.en) begin
            sign1 <= data1[W-1];
            sign2 <= is_sub ? ~data2[W-1] : data2[W-1];
        end
    end

    assign out = result_q[W-1:0];

    assign flags_out.bits.z = (result_q[W-1:0] == '0);
    assign flags_out.bits.c = result_q[W];
    assign flags_out.bits.n = result_q[W-1];
    assign flags_out.bits.v = ov_op && (sign1 == sign2) && (sign1 != result_q[W-1]);

endmodule

//--- alu_ctrl.sv
// ================================================
// alu control
// registered write-back, branch and link enables
// ================================================
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_ctrl (
    input  logic   clk,
    input  logic   rst_n,
    alu_op_if.ctrl op,
    input  logic   cond_true,
    output logic   write,
    output logic   should_branch,
    output logic   lr_wr_en
);

    logic no_write;
    logic is_branch;
    logic is_call;

    // ops with no register result
    always_comb begin
        case (op.opcode)
            `OPC_CMP,
            `OPC_TEST,
            `OPC_ST,
            `OPC_JMP,
            `OPC_PUSH,
            `OPC_CALL: no_write = 1'b1;
            default:   no_write = 1'b0;
        endcase
    end

    assign is_call   = (op.opcode == `OPC_CALL);
    assign is_branch = (op.opcode == `OPC_JMP) || is_call;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write         <= 1'b0;
            should_branch <= 1'b0;
            lr_wr_en      <= 1'b0;
        end else if (op.en) begin
            write         <= ~no_write;
            should_branch <= is_branch & cond_true;
            // link register only on a taken call
            lr_wr_en      <= is_call & cond_true;
        end
    end

endmodule

//--- alu_top.sv
// ================================================
// alu top
// 16-bit registered alu with one cycle latency
// ================================================
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_top import alu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic [7:0]            alu_control,
    input  logic                  en_imm,
    input  logic                  mem_displacement,
    input  logic [`ALU_WIDTH-1:0] rd_data,
    input  logic [`ALU_WIDTH-1:0] rs_data,
    input  logic [`ALU_WIDTH-1:0] immediate,
    input  logic [3:0]            condition,
    input  logic [3:0]            flags_in,
    output logic                  should_branch,
    output logic                  write,
    output logic                  lr_wr_en,
    output logic [`ALU_WIDTH-1:0] out,
    output logic [`ALU_WIDTH-1:0] mem_data,
    output logic [`ALU_WIDTH-1:0] sp_out,
    output logic [3:0]            flags_out
);

    alu_op_if u_op_if ();

    flags_u flags_q;
    logic   cond_true;

    assign u_op_if.en               = en;
    assign u_op_if.opcode           = alu_control;
    assign u_op_if.rd_data          = rd_data;
    assign u_op_if.rs_data          = rs_data;
    assign u_op_if.immediate        = immediate;
    assign u_op_if.en_imm           = en_imm;
    assign u_op_if.mem_displacement = mem_displacement;
    assign u_op_if.condition        = condition;
    assign u_op_if.flags_in.raw     = flags_in;

    assign flags_out = flags_q.raw;

    branch_cond u_branch_cond (
        .condition (u_op_if.condition),
        .flags     (u_op_if.flags_in),
        .cond_true (cond_true)
    );

    alu_exec u_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (u_op_if.exec),
        .cond_true (cond_true),
        .out       (out),
        .mem_data  (mem_data),
        .sp_out    (sp_out),
        .flags_out (flags_q)
    );

    alu_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .op            (u_op_if.ctrl),
        .cond_true     (cond_true),
        .write         (write),
        .should_branch (should_branch),
        .lr_wr_en      (lr_wr_en)
    );

endmodule

//--- alu_asserts.sv
// ================================================
// alu assertions
// control reset state, flags against the result
// ================================================
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  write,
    input logic                  should_branch,
    input logic                  lr_wr_en,
    input logic [`ALU_WIDTH-1:0] out,
    input logic [3:0]            flags_out
);

    // controls cleared one cycle into reset
    assert property (@(posedge clk) !rst_n |=> !write && !should_branch && !lr_wr_en)
        else $error("control outputs not cleared by reset");

    // n follows the sign bit of the result
    assert property (@(posedge clk) disable iff (!rst_n) flags_out[2] == out[`ALU_WIDTH-1])
        else $error("n flag differs from the sign bit of out");

    assert property (@(posedge clk) disable iff (!rst_n) flags_out[0] == (out == '0))
        else $error("z flag does not match a zero result");

endmodule

bind alu_top alu_asserts u_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .write         (write),
    .should_branch (should_branch),
    .lr_wr_en      (lr_wr_en),
    .out           (out),
    .flags_out     (flags_out)
);

//--- tb_alu_top.sv
// ================================================
// alu testbench
// operations from a case file, checked one cycle on
// ================================================
`timescale 1ns/1ps
`include "alu_macros.svh"

module tb_alu_top;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;

    logic                  clk;
    logic                  rst_n;
    logic                  en;
    logic [7:0]            alu_control;
    logic                  en_imm;
    logic                  mem_displacement;
    logic [`ALU_WIDTH-1:0] rd_data, rs_data, immediate;
    logic [3:0]            condition, flags_in, flags_out;
    logic                  should_branch, write, lr_wr_en;
    logic [`ALU_WIDTH-1:0] out, mem_data, sp_out;

    // 8 input fields and 7 expected fields per case
    logic [`ALU_WIDTH-1:0] stim_q [$];
    string                 expect_q [$];
    int                    case_count = 0;

    alu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // an expected field of x is skipped
    task automatic check_field(string name, string exp_s, logic [`ALU_WIDTH-1:0] act);
        logic [`ALU_WIDTH-1:0] exp_v;
        if (exp_s != "x") begin
            void'($sscanf(exp_s, "%h", exp_v));
            assert (act === exp_v)
            else abort_run($sformatf("Error at %0d ns: %s expected %h, got %h",
                                     $time, name, exp_v, act));
        end
    endtask

    task automatic load_cases();
        int                    fd;
        string                 line;
        logic [`ALU_WIDTH-1:0] f [8];
        string                 e [7];
        fd = $fopen("alu_cases.txt", "r");
        if (fd == 0)
            abort_run("cannot open alu_cases.txt");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %s %s %s %s %s %s %s",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        e[0], e[1], e[2], e[3], e[4], e[5], e[6]) != 15)
                abort_run({"malformed line in case file: ", line});
            foreach (f[k])
                stim_q.push_back(f[k]);
            foreach (e[k])
                expect_q.push_back(e[k]);
        end
        $fclose(fd);
        case_count = stim_q.size() / 8;
    endtask

    task automatic apply_case(int idx);
        int b;
        b = idx * 8;
        en               <= 1'b1;
        alu_control      <= stim_q[b][7:0];
        en_imm           <= stim_q[b+1][0];
        mem_displacement <= stim_q[b+2][0];
        rd_data          <= stim_q[b+3];
        rs_data          <= stim_q[b+4];
        immediate        <= stim_q[b+5];
        condition        <= stim_q[b+6][3:0];
        flags_in         <= stim_q[b+7][3:0];
    endtask

    // new operands while en is low, none may reach the outputs
    task automatic randomize_idle_inputs();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $urandom;
        r2 = $urandom;
        alu_control      <= r1[7:0];
        en_imm           <= r1[8];
        mem_displacement <= r1[9];
        condition        <= r1[13:10];
        flags_in         <= r1[17:14];
        immediate        <= r1[31:16];
        rd_data          <= r2[15:0];
        rs_data          <= r2[31:16];
    endtask

    task automatic verify_outputs(int idx);
        int b;
        b = idx * 7;
        check_field("out", expect_q[b], out);
        check_field("flags_out", expect_q[b+1], {12'h0, flags_out});
        check_field("write", expect_q[b+2], {15'h0, write});
        check_field("should_branch", expect_q[b+3], {15'h0, should_branch});
        check_field("lr_wr_en", expect_q[b+4], {15'h0, lr_wr_en});
        check_field("mem_data", expect_q[b+5], mem_data);
        check_field("sp_out", expect_q[b+6], sp_out);
    endtask

    initial begin
        int gap;
        void'($urandom(87));
        rst_n            = 1'b0;
        en               = 1'b0;
        alu_control      = 8'h00;
        en_imm           = 1'b0;
        mem_displacement = 1'b0;
        rd_data          = '0;
        rs_data          = '0;
        immediate        = '0;
        condition        = 4'h0;
        flags_in         = 4'h0;
        load_cases();
        if (case_count == 0)
            abort_run("no operations found in alu_cases.txt");
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // before any operation only z is set
        @(negedge clk);
        check_field("out", "0", out);
        check_field("flags_out", "1", {12'h0, flags_out});
        check_field("write", "0", {15'h0, write});
        check_field("should_branch", "0", {15'h0, should_branch});
        check_field("lr_wr_en", "0", {15'h0, lr_wr_en});
        check_field("mem_data", "0", mem_data);
        check_field("sp_out", "0", sp_out);
        for (int i = 0; i < case_count; i++) begin
            @(posedge clk);
            apply_case(i);
            @(posedge clk);
            en <= 1'b0;
            randomize_idle_inputs();
            @(negedge clk);
            verify_outputs(i);
            // idle cycles with other inputs, every output holds
            gap = 1 + ($urandom % 2);
            repeat (gap) @(posedge clk);
            @(negedge clk);
            verify_outputs(i);
        end
        $display("Simulation passed");
        $finish;
    end

    // at most four cycles per case, plus reset and slack
    initial begin
        wait (case_count > 0);
        #((case_count + RESET_CYCLES + 20) * CLK_PERIOD * 4);
        abort_run("watchdog timeout, the run did not finish in time");
    end

endmodule

//--- build.f
+incdir+.
alu_pkg.sv
alu_op_if.sv
branch_cond.sv
alu_exec.sv
alu_ctrl.sv
alu_top.sv
alu_asserts.sv
tb_alu_top.sv

//--- Makefile
TOP := tb_alu_top

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	result=$$(./obj_dir/V$(TOP)); echo "$$result"; echo "$$result" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- alu_cases.txt
# inputs: opcode en_imm mem_displacement rd_data rs_data immediate condition flags_in
# expected: out flags_out write should_branch lr_wr_en mem_data sp_out (x is not checked)
00 0 0 1234 4321 0000 0 0 5555 0 1 0 0 x x
00 1 0 7fff ffff 0001 0 0 8000 c 1 0 0 x x
01 0 0 0005 0007 0000 0 0 fffe 6 1 0 0 x x
01 1 0 8000 0000 0001 0 0 7fff 8 1 0 0 x x
02 1 0 ffff 1234 0000 0 2 0000 3 1 0 0 x x
03 0 0 0000 0000 0000 0 2 ffff 6 1 0 0 x x
04 0 0 1234 1234 0000 0 0 0000 1 0 0 0 x x
09 0 0 0001 0000 0000 0 0 ffff 4 1 0 0 x x
05 0 0 f0f0 ff00 0000 0 0 f000 4 1 0 0 x x
06 1 0 0f00 ffff 00f0 0 0 0ff0 0 1 0 0 x x
07 0 0 aaaa aaaa 0000 0 0 0000 1 1 0 0 x x
08 0 0 00ff 0000 0000 0 0 ff00 4 1 0 0 x x
0a 0 0 1200 0034 0000 0 0 0000 1 0 0 0 x x
0b 1 0 0000 0000 8001 0 0 8001 4 1 0 0 x x
0c 0 0 c001 0001 0000 0 0 8002 6 1 0 0 x x
0d 1 0 ffff 0000 0010 0 0 0000 1 1 0 0 x x
0e 0 0 8000 0013 0000 0 0 f000 4 1 0 0 x x
0f 1 0 8001 0000 0014 0 0 0018 0 1 0 0 x x
10 0 0 0000 0000 0000 0 0 0001 0 1 0 0 x x
10 0 0 0000 0000 0000 1 f 0000 1 1 0 0 x x
10 0 0 0000 0000 0000 2 1 0001 0 1 0 0 x x
10 0 0 0000 0000 0000 3 1 0000 1 1 0 0 x x
10 0 0 0000 0000 0000 4 2 0001 0 1 0 0 x x
10 0 0 0000 0000 0000 5 2 0000 1 1 0 0 x x
10 0 0 0000 0000 0000 6 8 0001 0 1 0 0 x x
10 0 0 0000 0000 0000 7 8 0000 1 1 0 0 x x
10 0 0 0000 0000 0000 8 4 0000 1 1 0 0 x x
10 0 0 0000 0000 0000 9 4 0001 0 1 0 0 x x
10 0 0 0000 0000 0000 c c 0001 0 1 0 0 x x
10 0 0 0000 0000 0000 d 8 0001 0 1 0 0 x x
11 0 0 0000 0000 0000 0 b 000b 0 1 0 0 x x
11 0 0 0000 0000 0000 3 b 0000 1 1 0 0 x x
12 1 0 1111 0000 0200 a 0 0200 0 0 1 0 x x
12 0 0 0300 0000 0000 b 0 0300 0 0 0 0 x x
13 1 0 0000 0000 0400 e d 0400 0 0 0 0 x x
13 0 0 8500 0000 0000 f 1 8500 4 0 1 1 x x
14 1 0 0000 2000 1000 0 0 1000 0 1 0 0 0000 0000
15 0 1 beef 2000 0010 0 0 2010 0 0 0 0 beef 0000
16 1 0 1234 1000 00aa 0 0 0ffe 0 0 0 0 00aa 0ffe
16 0 0 5678 0000 0000 0 0 fffe 4 0 0 0 5678 fffe
17 0 0 0000 fffe 0000 0 0 fffe 4 1 0 0 5678 0000
